// File: Makefile
# Verilator simulation of the Wishbone system

VERILATOR ?= verilator
SIM_TOP   ?= tb_wb0_system
FILELIST  ?= wb0_system.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= Simulation finished: FAIL
PASS_MSG  ?= Simulation finished: PASS

SRCS := $(wildcard rtl/*.sv) $(wildcard test/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(SIM_TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

$(SIM_BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(SIM_TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "test failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "no result in $(LOG)"; exit 1; fi
	@echo "test passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: rtl/data_mem.sv
`timescale 1ns/100ps

module data_mem (
    input  logic            wb_clk_i,
    input  logic            rst_n_i,
    input  wb_pkg::wb_req_t req_i,
    output wb_pkg::wb_rsp_t rsp_o
);

    logic [wb_pkg::WB_DWIDTH-1:0]       mem [periph_pkg::DMEM_WORDS];
    logic [periph_pkg::DMEM_AWIDTH-1:0] word_adr;
    logic [wb_pkg::WB_DWIDTH-1:0]       rd_q;
    logic                               ack_q;
    logic                               accept;

    // Word index from byte address
    assign word_adr = req_i.adr[periph_pkg::DMEM_AWIDTH+1:2];

    // No new access in the ack cycle
    assign accept = req_i.cyc & req_i.stb & ~ack_q;

    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= accept;
        end
    end

    // Byte lane writes
    always_ff @(posedge wb_clk_i) begin
        if (accept && req_i.we) begin
            for (int b = 0; b < wb_pkg::WB_SWIDTH; b++) begin
                if (req_i.sel[b]) begin
                    mem[word_adr][8*b +: 8] <= req_i.dat[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (accept && !req_i.we) begin
            rd_q <= mem[word_adr];
        end
    end

    assign rsp_o = '{dat: rd_q, ack: ack_q, err: 1'b0};

    a_ack_pulse: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
        ack_q |=> !ack_q)
        else $error("data memory ack longer than one cycle");

endmodule

// File: rtl/periph_pkg.sv
package periph_pkg;

    // Data memory size
    localparam int DMEM_WORDS  = 1024;
    localparam int DMEM_AWIDTH = 10;

    // ------------------------------------------------------------
    // Interrupt controller
    // ------------------------------------------------------------
    localparam int PIC_SOURCES   = 16;
    localparam int PIC_REG_WIDTH = 8;

    // Word offsets, address bits 4:2
    typedef enum logic [2:0] {
        PIC_PEND_LO = 3'd0,
        PIC_PEND_HI = 3'd1,
        PIC_EN_LO   = 3'd2,
        PIC_EN_HI   = 3'd3
    } pic_reg_e;

    // ------------------------------------------------------------
    // GPIO and soft reset
    // ------------------------------------------------------------
    localparam int GPIO_WIDTH = 8;

    typedef enum logic [2:0] {
        GPIO_OUT   = 3'd0,
        GPIO_DIR   = 3'd1,
        GPIO_IN    = 3'd2,
        GPIO_IBASE = 3'd3,
        GPIO_CTRL  = 3'd4
    } gpio_reg_e;

    localparam int SOFT_RST_CYCLES = 4;
    localparam int SOFT_RST_CW     = $clog2(SOFT_RST_CYCLES);
    // Counter start value, pulse ends when it reaches zero
    localparam logic [SOFT_RST_CW-1:0] SOFT_RST_LOAD = SOFT_RST_CW'(SOFT_RST_CYCLES - 1);

    typedef enum logic {
        SR_IDLE   = 1'b0,
        SR_ACTIVE = 1'b1
    } soft_rst_state_e;

endpackage

// File: rtl/simple_gpio.sv
`timescale 1ns/100ps

module simple_gpio (
    input  logic                              wb_clk_i,
    input  logic                              rst_n_i,
    input  logic                              sys_rst_n_i,
    input  wb_pkg::wb_req_t                   req_i,
    output wb_pkg::wb_rsp_t                   rsp_o,
    input  logic [periph_pkg::GPIO_WIDTH-1:0] gpio_i,
    output logic [periph_pkg::GPIO_WIDTH-1:0] gpio_o,
    output logic [periph_pkg::GPIO_WIDTH-1:0] gpio_oe_o,
    output logic [7:0]                        ibase_o,
    output logic                              soft_rst_o
);

    logic [periph_pkg::GPIO_WIDTH-1:0]  out_q;
    logic [periph_pkg::GPIO_WIDTH-1:0]  dir_q;
    logic [periph_pkg::GPIO_WIDTH-1:0]  in_meta;
    logic [periph_pkg::GPIO_WIDTH-1:0]  in_sync;
    logic [periph_pkg::GPIO_WIDTH-1:0]  wdat;
    logic [periph_pkg::GPIO_WIDTH-1:0]  rdat;
    logic [7:0]                         ibase_q;
    logic [wb_pkg::WB_DWIDTH-1:0]       rd_q;
    logic [periph_pkg::SOFT_RST_CW-1:0] cnt_q;
    periph_pkg::gpio_reg_e              ofs;
    periph_pkg::soft_rst_state_e        state_q;
    logic                               ack_q;
    logic                               accept;
    logic                               wr;
    logic                               start_q;

    assign ofs    = periph_pkg::gpio_reg_e'(req_i.adr[4:2]);
    assign accept = req_i.cyc & req_i.stb & ~ack_q;
    assign wr     = accept & req_i.we & req_i.sel[0];
    assign wdat   = req_i.dat[periph_pkg::GPIO_WIDTH-1:0];

    // Pin input synchronizer
    always_ff @(posedge wb_clk_i) begin
        in_meta <= gpio_i;
        in_sync <= in_meta;
    end

    always_ff @(posedge wb_clk_i) begin
        if (!sys_rst_n_i) begin
            out_q <= '0;
            dir_q <= '0;
            ack_q <= 1'b0;
        end else begin
            if (wr && ofs == periph_pkg::GPIO_OUT) begin
                out_q <= wdat;
            end
            if (wr && ofs == periph_pkg::GPIO_DIR) begin
                dir_q <= wdat;
            end
            ack_q <= accept;
        end
    end

    // Instruction base survives the soft reset
    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            ibase_q <= '0;
        end else if (wr && ofs == periph_pkg::GPIO_IBASE) begin
            ibase_q <= wdat;
        end
    end

    always_comb begin
        rdat = '0;
        case (ofs)
            periph_pkg::GPIO_OUT:   rdat = out_q;
            periph_pkg::GPIO_DIR:   rdat = dir_q;
            periph_pkg::GPIO_IN:    rdat = in_sync;
            periph_pkg::GPIO_IBASE: rdat = ibase_q;
            periph_pkg::GPIO_CTRL:  rdat[0] = soft_rst_o;
            default:                rdat = '0;
        endcase
    end

    always_ff @(posedge wb_clk_i) begin
        if (accept) begin
            rd_q <= {{(wb_pkg::WB_DWIDTH - periph_pkg::GPIO_WIDTH){1'b0}}, rdat};
        end
    end

    // ------------------------------------------------------------
    // Soft reset sequencer, pulse starts the cycle after ack
    // ------------------------------------------------------------
    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            start_q <= 1'b0;
            state_q <= periph_pkg::SR_IDLE;
            cnt_q   <= '0;
        end else begin
            start_q <= wr && ofs == periph_pkg::GPIO_CTRL && req_i.dat[0];
            case (state_q)
                periph_pkg::SR_IDLE: begin
                    if (start_q) begin
                        state_q <= periph_pkg::SR_ACTIVE;
                        cnt_q   <= periph_pkg::SOFT_RST_LOAD;
                    end
                end
                periph_pkg::SR_ACTIVE: begin
                    if (cnt_q == '0) begin
                        state_q <= periph_pkg::SR_IDLE;
                    end else begin
                        cnt_q <= cnt_q - 1'b1;
                    end
                end
                default: state_q <= periph_pkg::SR_IDLE;
            endcase
        end
    end

    assign soft_rst_o = (state_q == periph_pkg::SR_ACTIVE);
    assign gpio_o     = out_q;
    assign gpio_oe_o  = dir_q;
    assign ibase_o    = ibase_q;
    assign rsp_o      = '{dat: rd_q, ack: ack_q, err: 1'b0};

    a_soft_rst_len: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
        $rose(soft_rst_o) |-> ##(periph_pkg::SOFT_RST_CYCLES) !soft_rst_o)
        else $error("soft reset pulse too long");

endmodule

// File: rtl/simple_pic.sv
`timescale 1ns/100ps

module simple_pic (
    input  logic                               wb_clk_i,
    input  logic                               rst_n_i,
    input  wb_pkg::wb_req_t                    req_i,
    output wb_pkg::wb_rsp_t                    rsp_o,
    input  logic [periph_pkg::PIC_SOURCES-1:0] irq_i,
    output logic [1:0]                         irq_o
);

    logic [periph_pkg::PIC_SOURCES-1:0]   pend_q;
    logic [periph_pkg::PIC_SOURCES-1:0]   en_q;
    logic [periph_pkg::PIC_SOURCES-1:0]   clr;
    logic [periph_pkg::PIC_REG_WIDTH-1:0] wdat;
    logic [periph_pkg::PIC_REG_WIDTH-1:0] rdat;
    logic [wb_pkg::WB_DWIDTH-1:0]         rd_q;
    periph_pkg::pic_reg_e                 ofs;
    logic                                 ack_q;
    logic                                 accept;
    logic                                 wr;

    assign ofs    = periph_pkg::pic_reg_e'(req_i.adr[4:2]);
    assign accept = req_i.cyc & req_i.stb & ~ack_q;
    assign wr     = accept & req_i.we & req_i.sel[0];
    assign wdat   = req_i.dat[periph_pkg::PIC_REG_WIDTH-1:0];

    // Register decode, write-one-to-clear on pending
    always_comb begin
        clr  = '0;
        rdat = '0;
        case (ofs)
            periph_pkg::PIC_PEND_LO: begin
                clr[0 +: periph_pkg::PIC_REG_WIDTH] = wr ? wdat : '0;
                rdat = pend_q[0 +: periph_pkg::PIC_REG_WIDTH];
            end
            periph_pkg::PIC_PEND_HI: begin
                clr[periph_pkg::PIC_REG_WIDTH +: periph_pkg::PIC_REG_WIDTH] = wr ? wdat : '0;
                rdat = pend_q[periph_pkg::PIC_REG_WIDTH +: periph_pkg::PIC_REG_WIDTH];
            end
            periph_pkg::PIC_EN_LO: rdat = en_q[0 +: periph_pkg::PIC_REG_WIDTH];
            periph_pkg::PIC_EN_HI: rdat = en_q[periph_pkg::PIC_REG_WIDTH +: periph_pkg::PIC_REG_WIDTH];
            default:               rdat = '0;
        endcase
    end

    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            pend_q <= '0;
            en_q   <= '0;
            irq_o  <= '0;
            ack_q  <= 1'b0;
        end else begin
            // A source that is still high beats the clear
            pend_q <= (pend_q & ~clr) | irq_i;
            if (wr && ofs == periph_pkg::PIC_EN_LO) begin
                en_q[0 +: periph_pkg::PIC_REG_WIDTH] <= wdat;
            end
            if (wr && ofs == periph_pkg::PIC_EN_HI) begin
                en_q[periph_pkg::PIC_REG_WIDTH +: periph_pkg::PIC_REG_WIDTH] <= wdat;
            end
            for (int g = 0; g < periph_pkg::PIC_SOURCES / periph_pkg::PIC_REG_WIDTH; g++) begin
                irq_o[g] <= |(pend_q[g*periph_pkg::PIC_REG_WIDTH +: periph_pkg::PIC_REG_WIDTH]
                            & en_q[g*periph_pkg::PIC_REG_WIDTH +: periph_pkg::PIC_REG_WIDTH]);
            end
            ack_q <= accept;
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (accept) begin
            rd_q <= {{(wb_pkg::WB_DWIDTH - periph_pkg::PIC_REG_WIDTH){1'b0}}, rdat};
        end
    end

    assign rsp_o = '{dat: rd_q, ack: ack_q, err: 1'b0};

    // irq_o lags the enables by one cycle
    for (genvar g = 0; g < 2; g++) begin : g_irq_chk
        a_irq_en: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
            irq_o[g] |-> $past(|en_q[g*periph_pkg::PIC_REG_WIDTH +: periph_pkg::PIC_REG_WIDTH]))
            else $error("irq_o[%0d] high with group disabled", g);
    end

endmodule

// File: rtl/wb0_intercon.sv
`timescale 1ns/100ps

module wb0_intercon (
    input  logic            wb_clk_i,
    input  logic            rst_n_i,
    input  wb_pkg::wb_req_t wb_req_i,
    output wb_pkg::wb_rsp_t wb_rsp_o,
    output wb_pkg::wb_req_t dmem_req_o,
    output wb_pkg::wb_req_t pic_req_o,
    output wb_pkg::wb_req_t gpio_req_o,
    input  wb_pkg::wb_rsp_t dmem_rsp_i,
    input  wb_pkg::wb_rsp_t pic_rsp_i,
    input  wb_pkg::wb_rsp_t gpio_rsp_i
);

    wb_pkg::slave_e slv;
    logic           hit_dmem;
    logic           hit_pic;
    logic           hit_gpio;
    logic           unmapped;
    logic           err_q;

    // Pass a request through with cyc and stb qualified by the decode
    function automatic wb_pkg::wb_req_t gate_req(input wb_pkg::wb_req_t req, input logic hit);
        wb_pkg::wb_req_t r;
        r     = req;
        r.cyc = req.cyc & hit;
        r.stb = req.stb & hit;
        return r;
    endfunction

    // ------------------------------------------------------------
    // Address decode
    // ------------------------------------------------------------
    assign slv = wb_pkg::slave_e'(wb_req_i.adr[wb_pkg::WB_AWIDTH-1:wb_pkg::SLV_SEL_LSB]);

    assign hit_dmem = (slv == wb_pkg::SLV_DMEM);
    assign hit_pic  = (slv == wb_pkg::SLV_PIC);
    assign hit_gpio = (slv == wb_pkg::SLV_GPIO);
    assign unmapped = ~(hit_dmem | hit_pic | hit_gpio);

    assign dmem_req_o = gate_req(wb_req_i, hit_dmem);
    assign pic_req_o  = gate_req(wb_req_i, hit_pic);
    assign gpio_req_o = gate_req(wb_req_i, hit_gpio);

    // Error slave for holes in the map, same one-cycle response as a real slave
    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            err_q <= 1'b0;
        end else begin
            err_q <= wb_req_i.cyc & wb_req_i.stb & unmapped & ~err_q;
        end
    end

    // ------------------------------------------------------------
    // Response mux
    // ------------------------------------------------------------
    always_comb begin
        wb_rsp_o = '0;
        case (slv)
            wb_pkg::SLV_DMEM: wb_rsp_o = dmem_rsp_i;
            wb_pkg::SLV_PIC:  wb_rsp_o = pic_rsp_i;
            wb_pkg::SLV_GPIO: wb_rsp_o = gpio_rsp_i;
            default:          wb_rsp_o.err = err_q;
        endcase
    end

    a_one_strobe: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
        $onehot0({dmem_req_o.stb, pic_req_o.stb, gpio_req_o.stb}))
        else $error("more than one slave strobed");

    a_ack_err: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
        !(wb_rsp_o.ack && wb_rsp_o.err))
        else $error("ack and err high together");

endmodule

// File: rtl/wb0_system.sv
`timescale 1ns/100ps

module wb0_system (
    input  logic                               wb_clk_i,
    input  logic                               rst_n_i,
    input  wb_pkg::wb_req_t                    wb_req_i,
    output wb_pkg::wb_rsp_t                    wb_rsp_o,
    input  logic [periph_pkg::PIC_SOURCES-1:0] irq_i,
    output logic [1:0]                         irq_o,
    input  logic [periph_pkg::GPIO_WIDTH-1:0]  gpio_i,
    output logic [periph_pkg::GPIO_WIDTH-1:0]  gpio_o,
    output logic [periph_pkg::GPIO_WIDTH-1:0]  gpio_oe_o,
    output logic [7:0]                         ibase_o
);

    wb_pkg::wb_req_t dmem_req;
    wb_pkg::wb_req_t pic_req;
    wb_pkg::wb_req_t gpio_req;
    wb_pkg::wb_rsp_t dmem_rsp;
    wb_pkg::wb_rsp_t pic_rsp;
    wb_pkg::wb_rsp_t gpio_rsp;
    logic            soft_rst;
    logic            sys_rst_n;

    // Board reset or GPIO-triggered reset
    assign sys_rst_n = rst_n_i & ~soft_rst;

    // ------------------------------------------------------------
    // Bus decode
    // ------------------------------------------------------------
    wb0_intercon u_wb0_intercon (
        .wb_clk_i   ( wb_clk_i  ),
        .rst_n_i    ( sys_rst_n ),
        .wb_req_i   ( wb_req_i  ),
        .wb_rsp_o   ( wb_rsp_o  ),
        .dmem_req_o ( dmem_req  ),
        .pic_req_o  ( pic_req   ),
        .gpio_req_o ( gpio_req  ),
        .dmem_rsp_i ( dmem_rsp  ),
        .pic_rsp_i  ( pic_rsp   ),
        .gpio_rsp_i ( gpio_rsp  )
    );

    // ------------------------------------------------------------
    // Slaves
    // ------------------------------------------------------------
    data_mem u_dmem (
        .wb_clk_i ( wb_clk_i  ),
        .rst_n_i  ( sys_rst_n ),
        .req_i    ( dmem_req  ),
        .rsp_o    ( dmem_rsp  )
    );

    simple_pic u_simple_pic (
        .wb_clk_i ( wb_clk_i  ),
        .rst_n_i  ( sys_rst_n ),
        .req_i    ( pic_req   ),
        .rsp_o    ( pic_rsp   ),
        .irq_i    ( irq_i     ),
        .irq_o    ( irq_o     )
    );

    simple_gpio u_gpio (
        .wb_clk_i    ( wb_clk_i  ),
        .rst_n_i     ( rst_n_i   ),
        .sys_rst_n_i ( sys_rst_n ),
        .req_i       ( gpio_req  ),
        .rsp_o       ( gpio_rsp  ),
        .gpio_i      ( gpio_i    ),
        .gpio_o      ( gpio_o    ),
        .gpio_oe_o   ( gpio_oe_o ),
        .ibase_o     ( ibase_o   ),
        .soft_rst_o  ( soft_rst  )
    );

endmodule

// File: rtl/wb_pkg.sv
package wb_pkg;

    // ------------------------------------------------------------
    // Bus widths
    // ------------------------------------------------------------
    localparam int WB_AWIDTH   = 16;
    localparam int WB_DWIDTH   = 32;
    localparam int WB_SWIDTH   = 4;

    // Slave select field sits in the top address nibble
    localparam int SLV_SEL_LSB = 12;

    // Master to slave
    typedef struct packed {
        logic [WB_AWIDTH-1:0] adr;
        logic [WB_DWIDTH-1:0] dat;
        logic [WB_SWIDTH-1:0] sel;
        logic                 we;
        logic                 cyc;
        logic                 stb;
    } wb_req_t;

    // Slave to master
    typedef struct packed {
        logic [WB_DWIDTH-1:0] dat;
        logic                 ack;
        logic                 err;
    } wb_rsp_t;

    // Address map, any other nibble is unmapped
    typedef enum logic [WB_AWIDTH-SLV_SEL_LSB-1:0] {
        SLV_DMEM = 4'h0,
        SLV_PIC  = 4'h4,
        SLV_GPIO = 4'h5
    } slave_e;

endpackage

// File: test/tb_wb0_system.sv
`timescale 1ns/100ps

module tb_wb0_system;

    localparam int TIMEOUT_CYCLES = 20;

    logic                               clk;
    logic                               rst_n;
    wb_pkg::wb_req_t                    req;
    wb_pkg::wb_rsp_t                    rsp;
    logic [periph_pkg::PIC_SOURCES-1:0] irq_in;
    logic [1:0]                         irq_out;
    logic [periph_pkg::GPIO_WIDTH-1:0]  gpio_in;
    logic [periph_pkg::GPIO_WIDTH-1:0]  gpio_out;
    logic [periph_pkg::GPIO_WIDTH-1:0]  gpio_oe;
    logic [7:0]                         ibase;
    int                                 checks;
    int                                 errors;
    int                                 timeouts;

    wb0_system UUT (
        .wb_clk_i  ( clk      ),
        .rst_n_i   ( rst_n    ),
        .wb_req_i  ( req      ),
        .wb_rsp_o  ( rsp      ),
        .irq_i     ( irq_in   ),
        .irq_o     ( irq_out  ),
        .gpio_i    ( gpio_in  ),
        .gpio_o    ( gpio_out ),
        .gpio_oe_o ( gpio_oe  ),
        .ibase_o   ( ibase    )
    );

    // 100 ns clock
    always #50 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
        end
    endtask

    // ------------------------------------------------------------
    // Bus master
    // ------------------------------------------------------------
    task automatic run_cycle(input logic [15:0] adr, input logic we, input logic [31:0] dat,
                             input logic [3:0] sel, output logic ack, output logic err,
                             output logic [31:0] rdat);
        int waited;
        waited  = 0;
        req.adr = adr;
        req.dat = dat;
        req.sel = sel;
        req.we  = we;
        req.cyc = 1'b1;
        req.stb = 1'b1;
        // Responses are registered, so poll on falling edges
        do begin
            @(negedge clk);
            waited++;
        end while (!(rsp.ack || rsp.err) && waited < TIMEOUT_CYCLES);
        ack     = rsp.ack;
        err     = rsp.err;
        rdat    = rsp.dat;
        req.cyc = 1'b0;
        req.stb = 1'b0;
        req.we  = 1'b0;
        if (!(ack || err)) begin
            timeouts++;
            $display("no response from bus at address %h", adr);
        end
    endtask

    task automatic write_word(input logic [15:0] adr, input logic [31:0] dat,
                              input logic [3:0] sel, output logic ack, output logic err);
        logic [31:0] unused_dat;
        run_cycle(adr, 1'b1, dat, sel, ack, err, unused_dat);
    endtask

    task automatic read_word(input logic [15:0] adr, output logic ack, output logic err,
                             output logic [31:0] rdat);
        run_cycle(adr, 1'b0, 32'h0, 4'hf, ack, err, rdat);
    endtask

    // ------------------------------------------------------------
    // Case file interpreter
    // ------------------------------------------------------------
    initial begin
        int          fd;
        string       line;
        byte         op;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        logic        ack;
        logic        err;
        logic [31:0] rdat;

        clk      = 1'b0;
        rst_n    = 1'b0;
        req      = '0;
        irq_in   = '0;
        gpio_in  = '0;
        checks   = 0;
        errors   = 0;
        timeouts = 0;
        void'($urandom(47));

        fd = $fopen("test/wb0_cases.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("cannot open the case file test/wb0_cases.txt");
        end

        repeat (2) @(negedge clk);
        rst_n = 1'b1;

        while (fd != 0 && !$feof(fd) && timeouts == 0) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            void'($sscanf(line, "%c %h %h %h", op, f1, f2, f3));
            case (op)
                "W": begin
                    repeat ($urandom % 4) @(negedge clk);
                    write_word(f1[15:0], f2, f3[3:0], ack, err);
                    check_value("write ack", 32'h1, 32'(ack));
                    check_value("write err", 32'h0, 32'(err));
                end
                "R": begin
                    repeat ($urandom % 4) @(negedge clk);
                    read_word(f1[15:0], ack, err, rdat);
                    check_value("read ack", 32'h1, 32'(ack));
                    check_value("read err", 32'h0, 32'(err));
                    check_value("wb_rsp_o.dat", f2, rdat);
                end
                "E": begin
                    repeat ($urandom % 4) @(negedge clk);
                    read_word(f1[15:0], ack, err, rdat);
                    check_value("unmapped err", 32'h1, 32'(err));
                    check_value("unmapped ack", 32'h0, 32'(ack));
                    check_value("unmapped dat", 32'h0, rdat);
                end
                "I": begin
                    irq_in = f1[15:0];
                    // Pending sets on the first edge, irq_o on the second
                    repeat (2) @(negedge clk);
                end
                "Q": check_value("irq_o", f1, 32'(irq_out));
                "G": begin
                    gpio_in = f1[7:0];
                    // Two-flop synchronizer
                    repeat (2) @(negedge clk);
                end
                "P": begin
                    check_value("gpio_o", f1, 32'(gpio_out));
                    check_value("gpio_oe_o", f2, 32'(gpio_oe));
                    check_value("ibase_o", f3, 32'(ibase));
                end
                "S": repeat (periph_pkg::SOFT_RST_CYCLES + 1) @(negedge clk);
                default: begin
                    errors++;
                    $display("unknown opcode in case file line: %s", line);
                end
            endcase
        end

        if (fd != 0) begin
            $fclose(fd);
        end
        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: test/wb0_cases.txt
# op then hex fields: W adr dat sel, R adr expected, E adr, I irq_i, Q irq_o
# G gpio_i, P gpio_o gpio_oe_o ibase_o, S waits out the soft reset
P 00 00 00
W 0000 12345678 F
W 0004 DEADBEEF F
W 0FFC CAFEF00D F
R 0000 12345678
R 0FFC CAFEF00D
W 0004 000000AA 1
W 0004 55660000 C
R 0004 5566BEAA
E 9000
R 0000 12345678
E F004
W 4008 08 1
I 0008
Q 1
I 0000
W 4000 08 1
R 4000 00000000
Q 0
I 0100
R 4004 00000001
Q 0
I 0000
W 4004 01 1
W 5000 A5 1
W 5004 0F 1
W 500C 5A 1
P A5 0F 5A
G 3C
R 5008 0000003C
W 400C 01 1
I 0008
Q 1
W 5010 01 1
S
Q 0
R 4008 00000000
R 400C 00000000
P 00 00 5A
R 0000 12345678
R 0004 5566BEAA

// File: wb0_system.f
rtl/wb_pkg.sv
rtl/periph_pkg.sv
rtl/wb0_intercon.sv
rtl/data_mem.sv
rtl/simple_pic.sv
rtl/simple_gpio.sv
rtl/wb0_system.sv
test/tb_wb0_system.sv
